//--- rtl/ex_params.svh
// --------------------
// Execute stage parameters
// Widths and instruction sizes shared by RTL and testbench
// --------------------

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data path width
`define EX_XLEN 32

// Scoreboard tag and CSR address widths
`define EX_TRANS_ID_BITS 3
`define EX_CSR_ADDR_BITS 12

// Instruction sizes in bytes, used for the link address
`define EX_INSTR_BYTES 4
`define EX_CINSTR_BYTES 2

`endif

//--- rtl/ex_pkg.sv
// --------------------
// Execute stage package
// Vector types, operation encoding and the records passed between units
// --------------------

`default_nettype none

`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]          xlen_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [3:0]                   cause_t;

    // Exception causes raised in this stage
    localparam cause_t CAUSE_INSTR_MISALIGNED = 4'd0;

    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Branch comparisons and register jump
        EQ, NE, LTS, GES, LTU, GEU, JALR,
        // CSR
        CSR_ACCESS,
        // Multiplier
        MUL, MULH, MULHU
    } fu_op_t;

    typedef struct packed {
        fu_op_t    operation;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    typedef struct packed {
        logic  taken;
        xlen_t predicted_address;
    } branch_predict_t;

    typedef struct packed {
        xlen_t pc;
        xlen_t target_address;
        logic  is_taken;
        logic  is_mispredict;
    } bp_resolve_t;

    typedef struct packed {
        logic   valid;
        cause_t cause;
        xlen_t  tval;
    } exception_t;

    // One claim on the scoreboard write-back port
    typedef struct packed {
        logic      valid;
        trans_id_t trans_id;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire

//--- rtl/ex_alu.sv
// --------------------
// Single-cycle ALU
// Arithmetic, logic, shifts, set-less-than and branch comparisons
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::fu_data_t fu_data_i,
    input  logic             alu_valid_i,
    output ex_pkg::wb_t      result_o,
    output logic             branch_res_o
);
    import ex_pkg::*;

    localparam int unsigned SHAMT_BITS = $clog2($bits(xlen_t));

    xlen_t                 op_a;
    xlen_t                 op_b;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  is_equal;
    logic                  less_signed;
    logic                  less_unsigned;
    xlen_t                 alu_result;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign shamt = op_b[SHAMT_BITS-1:0];

    // Comparators shared by SLT(U) and branches
    assign is_equal      = (op_a == op_b);
    assign less_signed   = ($signed(op_a) < $signed(op_b));
    assign less_unsigned = (op_a < op_b);

    always_comb begin
        case (fu_data_i.operation)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            AND:     alu_result = op_a & op_b;
            OR:      alu_result = op_a | op_b;
            XOR:     alu_result = op_a ^ op_b;
            SLL:     alu_result = op_a << shamt;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = xlen_t'($signed(op_a) >>> shamt);
            SLT:     alu_result = xlen_t'(less_signed);
            SLTU:    alu_result = xlen_t'(less_unsigned);
            default: alu_result = '0;
        endcase
    end

    // Branch condition, only meaningful for conditional branches
    always_comb begin
        case (fu_data_i.operation)
            EQ:      branch_res_o = is_equal;
            NE:      branch_res_o = ~is_equal;
            LTS:     branch_res_o = less_signed;
            GES:     branch_res_o = ~less_signed;
            LTU:     branch_res_o = less_unsigned;
            GEU:     branch_res_o = ~less_unsigned;
            default: branch_res_o = 1'b0;
        endcase
    end

    assign result_o.valid    = alu_valid_i;
    assign result_o.trans_id = fu_data_i.trans_id;
    assign result_o.data     = alu_result;

endmodule

`default_nettype wire

//--- rtl/ex_branch_unit.sv
// --------------------
// Branch unit
// Resolves conditional branches and JALR against the frontend prediction
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_branch_unit (
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::xlen_t           pc_i,
    input  logic                    is_compressed_instr_i,
    input  logic                    branch_valid_i,
    input  logic                    branch_comp_res_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output ex_pkg::wb_t             link_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o,
    output logic                    resolve_branch_o,
    output ex_pkg::exception_t      branch_exception_o
);
    import ex_pkg::*;

    logic  is_jump;
    logic  taken;
    xlen_t target_base;
    xlen_t target;
    xlen_t link_addr;
    logic  dir_wrong;
    logic  addr_wrong;

    assign is_jump     = (fu_data_i.operation == JALR);
    assign target_base = is_jump ? fu_data_i.operand_a : pc_i;

    // JALR clears bit 0 of the computed target
    always_comb begin
        target = target_base + fu_data_i.imm;
        if (is_jump) begin
            target[0] = 1'b0;
        end
    end

    assign taken     = is_jump | branch_comp_res_i;
    assign link_addr = pc_i + (is_compressed_instr_i ? xlen_t'(`EX_CINSTR_BYTES)
                                                     : xlen_t'(`EX_INSTR_BYTES));

    // --------------------
    // Resolution
    // --------------------
    assign dir_wrong  = (taken != branch_predict_i.taken);
    assign addr_wrong = taken & (target != branch_predict_i.predicted_address);

    assign resolve_branch_o                 = branch_valid_i;
    assign resolved_branch_o.pc             = pc_i;
    assign resolved_branch_o.target_address = target;
    assign resolved_branch_o.is_taken       = taken;
    assign resolved_branch_o.is_mispredict  = branch_valid_i & (dir_wrong | addr_wrong);

    assign link_o.valid    = branch_valid_i;
    assign link_o.trans_id = fu_data_i.trans_id;
    assign link_o.data     = link_addr;

    // Taken target must be 4-byte aligned without compressed support
    assign branch_exception_o.valid = branch_valid_i & taken & target[1];
    assign branch_exception_o.cause = CAUSE_INSTR_MISALIGNED;
    assign branch_exception_o.tval  = target;

endmodule

`default_nettype wire

//--- rtl/ex_csr_buffer.sv
// --------------------
// CSR buffer
// Holds one CSR address until commit, blocks issue while full
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_csr_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              csr_valid_i,
    input  logic              csr_commit_i,
    input  ex_pkg::fu_data_t  fu_data_i,
    output ex_pkg::wb_t       result_o,
    output logic              csr_ready_o,
    output ex_pkg::csr_addr_t csr_addr_o
);
    import ex_pkg::*;

    logic      full_q;
    csr_addr_t addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address comes from the low bits of operand b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= csr_addr_t'(fu_data_i.operand_b);
        end
    end

    assign csr_ready_o = ~full_q;
    assign csr_addr_o  = addr_q;

    // Write data goes back to the scoreboard right away
    assign result_o.valid    = csr_valid_i;
    assign result_o.trans_id = fu_data_i.trans_id;
    assign result_o.data     = fu_data_i.operand_a;

endmodule

`default_nettype wire

//--- rtl/ex_multiplier.sv
// --------------------
// Multiplier
// One-cycle registered 32x32 product, low or high half
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_multiplier (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             mult_valid_i,
    input  ex_pkg::fu_data_t fu_data_i,
    output ex_pkg::wb_t      result_o
);
    import ex_pkg::*;

    localparam int unsigned XLEN = $bits(xlen_t);

    logic                   sign_ext;
    logic signed [XLEN:0]   op_a_ext;
    logic signed [XLEN:0]   op_b_ext;
    logic [2*XLEN+1:0]      product_full;
    logic                   valid_q;
    logic                   high_q;
    trans_id_t              trans_id_q;
    logic [2*XLEN-1:0]      product_q;

    // MULH is signed by signed, MULHU and MUL zero-extend
    assign sign_ext     = (fu_data_i.operation == MULH);
    assign op_a_ext     = {sign_ext & fu_data_i.operand_a[XLEN-1], fu_data_i.operand_a};
    assign op_b_ext     = {sign_ext & fu_data_i.operand_b[XLEN-1], fu_data_i.operand_b};
    assign product_full = op_a_ext * op_b_ext;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            product_q  <= product_full[2*XLEN-1:0];
            high_q     <= (fu_data_i.operation != MUL);
            trans_id_q <= fu_data_i.trans_id;
        end
    end

    // A flush also kills the result that is on the port right now
    assign result_o.valid    = valid_q & ~flush_i;
    assign result_o.trans_id = trans_id_q;
    assign result_o.data     = high_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];

endmodule

`default_nettype wire

//--- rtl/ex_writeback_arbiter.sv
// --------------------
// Write-back arbiter
// Fixed priority onto the shared scoreboard port
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_writeback_arbiter (
    input  ex_pkg::wb_t alu_i,
    input  ex_pkg::wb_t branch_i,
    input  ex_pkg::wb_t csr_i,
    input  ex_pkg::wb_t mult_i,
    output ex_pkg::wb_t wb_o
);
    import ex_pkg::*;

    // Grant vector, one bit per claim
    logic [3:0] grant;

    // Priority ALU > branch > CSR > multiplier
    assign grant[0] = alu_i.valid;
    assign grant[1] = branch_i.valid & ~alu_i.valid;
    assign grant[2] = csr_i.valid & ~alu_i.valid & ~branch_i.valid;
    assign grant[3] = mult_i.valid & ~alu_i.valid & ~branch_i.valid & ~csr_i.valid;

    always_comb begin
        wb_o = '0;
        case (1'b1)
            grant[0]: wb_o = alu_i;
            grant[1]: wb_o = branch_i;
            grant[2]: wb_o = csr_i;
            grant[3]: wb_o = mult_i;
            default: begin
                wb_o.valid    = 1'b0;
                wb_o.trans_id = '0;
                wb_o.data     = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_fixed_latency.sv
// --------------------
// Fixed-latency execute units
// ALU, branch unit, CSR buffer and multiplier on one write-back port
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_fixed_latency (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::xlen_t           pc_i,
    input  logic                    is_compressed_instr_i,
    input  logic                    alu_valid_i,
    input  logic                    branch_valid_i,
    input  logic                    csr_valid_i,
    input  logic                    csr_commit_i,
    input  logic                    mult_valid_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output ex_pkg::wb_t             flu_wb_o,
    output logic                    flu_ready_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o,
    output logic                    resolve_branch_o,
    output ex_pkg::exception_t      flu_exception_o,
    output ex_pkg::csr_addr_t       csr_addr_o
);
    import ex_pkg::*;

    // Comparison from ALU to branch unit
    logic alu_branch_res;

    wb_t  alu_wb;
    wb_t  branch_wb;
    wb_t  csr_wb;
    wb_t  mult_wb;

    // --------------------
    // Single-cycle units
    // --------------------
    ex_alu u_alu (
        .fu_data_i    (fu_data_i),
        .alu_valid_i  (alu_valid_i),
        .result_o     (alu_wb),
        .branch_res_o (alu_branch_res)
    );

    ex_branch_unit u_branch_unit (
        .fu_data_i             (fu_data_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .branch_valid_i        (branch_valid_i),
        .branch_comp_res_i     (alu_branch_res),
        .branch_predict_i      (branch_predict_i),
        .link_o                (branch_wb),
        .resolved_branch_o     (resolved_branch_o),
        .resolve_branch_o      (resolve_branch_o),
        .branch_exception_o    (flu_exception_o)
    );

    ex_csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .fu_data_i    (fu_data_i),
        .result_o     (csr_wb),
        .csr_ready_o  (flu_ready_o),
        .csr_addr_o   (csr_addr_o)
    );

    // Result lands one edge after issue
    ex_multiplier u_multiplier (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .fu_data_i    (fu_data_i),
        .result_o     (mult_wb)
    );

    ex_writeback_arbiter u_writeback_arbiter (
        .alu_i    (alu_wb),
        .branch_i (branch_wb),
        .csr_i    (csr_wb),
        .mult_i   (mult_wb),
        .wb_o     (flu_wb_o)
    );

endmodule

`default_nettype wire

//--- test/ex_properties.sv
// --------------------
// Execute stage issue rules
// Bound checks on the valid strobes and the CSR ready level
// --------------------

`timescale 1ns/1ps
`default_nettype none

module ex_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic flu_ready_i
);

    // One unit per issue slot
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one valid strobe in the same cycle");

    // Multiplier result owns the write-back port in the following cycle
    a_after_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("ALU, branch or CSR issue in the cycle after a multiply");

    a_csr_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_ready_i)
        else $error("CSR issue while the CSR buffer is full");

endmodule

bind ex_fixed_latency ex_properties u_properties (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .alu_valid_i    (alu_valid_i),
    .branch_valid_i (branch_valid_i),
    .csr_valid_i    (csr_valid_i),
    .mult_valid_i   (mult_valid_i),
    .flu_ready_i    (flu_ready_o)
);

`default_nettype wire

//--- test/ex_tb.sv
// --------------------
// Execute stage testbench
// Table-driven stimulus with a reference model for random rows
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_tb;
    import ex_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int READY_LIMIT = 20;

    // Row kinds
    localparam logic [2:0] K_IDLE   = 3'd0;
    localparam logic [2:0] K_ALU    = 3'd1;
    localparam logic [2:0] K_BR     = 3'd2;
    localparam logic [2:0] K_CSR    = 3'd3;
    localparam logic [2:0] K_MUL    = 3'd4;
    localparam logic [2:0] K_COMMIT = 3'd5;
    localparam logic [2:0] K_FLUSH  = 3'd6;

    typedef struct packed {
        logic [2:0] kind;
        fu_op_t     op;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        xlen_t      pc;
        logic       comp;
        logic       pred_taken;
        xlen_t      pred_addr;
        xlen_t      exp_data;
        xlen_t      exp_target;
        logic       exp_taken;
        logic       exp_mis;
        logic       exp_exc;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            flush;
    fu_data_t        fu_data;
    xlen_t           pc;
    logic            is_compressed;
    logic            alu_valid;
    logic            branch_valid;
    logic            csr_valid;
    logic            csr_commit;
    logic            mult_valid;
    branch_predict_t branch_predict;
    wb_t             flu_wb;
    logic            flu_ready;
    bp_resolve_t     resolved_branch;
    logic            resolve_branch;
    exception_t      flu_exception;
    csr_addr_t       csr_addr;

    row_t      rows[$];
    integer    seed;
    int        errors;
    int        checks;
    // Model state carried between rows
    logic      csr_full;
    csr_addr_t stored_addr;
    logic      pend_valid;
    xlen_t     pend_data;
    trans_id_t pend_tid;

    ex_fixed_latency UUT (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .flush_i               (flush),
        .fu_data_i             (fu_data),
        .pc_i                  (pc),
        .is_compressed_instr_i (is_compressed),
        .alu_valid_i           (alu_valid),
        .branch_valid_i        (branch_valid),
        .csr_valid_i           (csr_valid),
        .csr_commit_i          (csr_commit),
        .mult_valid_i          (mult_valid),
        .branch_predict_i      (branch_predict),
        .flu_wb_o              (flu_wb),
        .flu_ready_o           (flu_ready),
        .resolved_branch_o     (resolved_branch),
        .resolve_branch_o      (resolve_branch),
        .flu_exception_o       (flu_exception),
        .csr_addr_o            (csr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // Expected result of an ALU or multiplier operation
    function automatic xlen_t model_result(input fu_op_t op, input xlen_t a, input xlen_t b);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'b0, a} * {32'b0, b};
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            SLTU:    return {31'b0, a < b};
            MUL:     return uprod[31:0];
            MULH:    return sprod[63:32];
            MULHU:   return uprod[63:32];
            default: return '0;
        endcase
    endfunction

    task automatic add_fixed(input logic [2:0] kind, input fu_op_t op, input xlen_t a,
                             input xlen_t b, input xlen_t exp_data);
        row_t r;
        r          = '0;
        r.kind     = kind;
        r.op       = op;
        r.a        = a;
        r.b        = b;
        r.exp_data = exp_data;
        rows.push_back(r);
    endtask

    task automatic add_random(input logic [2:0] kind, input fu_op_t op);
        row_t r;
        r          = '0;
        r.kind     = kind;
        r.op       = op;
        r.a        = $random(seed);
        r.b        = $random(seed);
        r.exp_data = model_result(op, r.a, r.b);
        rows.push_back(r);
    endtask

    task automatic add_branch(input fu_op_t op, input xlen_t a, input xlen_t b, input xlen_t imm,
                              input xlen_t pc_val, input logic comp, input logic pt,
                              input xlen_t pa, input xlen_t target, input logic taken,
                              input logic mis, input logic exc);
        row_t r;
        r            = '0;
        r.kind       = K_BR;
        r.op         = op;
        r.a          = a;
        r.b          = b;
        r.imm        = imm;
        r.pc         = pc_val;
        r.comp       = comp;
        r.pred_taken = pt;
        r.pred_addr  = pa;
        // Link is the address of the next instruction
        r.exp_data   = pc_val + (comp ? 32'd2 : 32'd4);
        r.exp_target = target;
        r.exp_taken  = taken;
        r.exp_mis    = mis;
        r.exp_exc    = exc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_fixed(K_ALU, ADD, 32'h7fffffff, 32'h1, 32'h80000000);
        add_fixed(K_ALU, SUB, 32'h3, 32'h5, 32'hfffffffe);
        add_fixed(K_ALU, AND, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
        add_fixed(K_ALU, OR, 32'hf0f0f0f0, 32'hff00ff00, 32'hfff0fff0);
        add_fixed(K_ALU, XOR, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0);
        add_fixed(K_ALU, SLL, 32'h3, 32'h24, 32'h30);
        add_fixed(K_ALU, SRL, 32'h80000000, 32'h4, 32'h08000000);
        add_fixed(K_ALU, SRA, 32'h80000000, 32'h4, 32'hf8000000);
        add_fixed(K_ALU, SLT, 32'hffffffff, 32'h1, 32'h1);
        add_fixed(K_ALU, SLTU, 32'hffffffff, 32'h1, 32'h0);
        add_random(K_ALU, ADD);
        add_random(K_ALU, SUB);
        add_random(K_ALU, AND);
        add_random(K_ALU, OR);
        add_random(K_ALU, XOR);
        add_random(K_ALU, SLL);
        add_random(K_ALU, SRL);
        add_random(K_ALU, SRA);
        add_random(K_ALU, SLT);
        add_random(K_ALU, SLTU);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        // Correct, wrong direction and wrong address predictions
        add_branch(EQ, 5, 5, 32'h20, 32'h100, 0, 1, 32'h120, 32'h120, 1, 0, 0);
        add_branch(NE, 5, 5, 32'h40, 32'h200, 1, 1, 32'h240, 32'h240, 0, 1, 0);
        add_branch(LTS, 32'hffffffff, 1, 32'h10, 32'h300, 0, 1, 32'h400, 32'h310, 1, 1, 0);
        add_branch(GES, 32'hffffffff, 1, 32'h8, 32'h400, 0, 0, 0, 32'h408, 0, 0, 0);
        // Misaligned targets, taken then not taken
        add_branch(LTU, 1, 32'hffffffff, 32'h6, 32'h500, 0, 1, 32'h506, 32'h506, 1, 0, 1);
        add_branch(GEU, 1, 32'hffffffff, 32'h2, 32'h600, 0, 0, 0, 32'h602, 0, 0, 0);
        add_branch(JALR, 32'h1001, 0, 32'h10, 32'h700, 1, 0, 0, 32'h1010, 1, 1, 0);
        add_branch(JALR, 32'h2000, 0, 32'h3, 32'h800, 0, 1, 32'h2002, 32'h2002, 1, 0, 1);
        // CSR buffer released by commit, then by flush
        add_fixed(K_CSR, CSR_ACCESS, 32'hdeadbeef, 32'h12345abc, 32'hdeadbeef);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_fixed(K_COMMIT, ADD, 0, 0, 0);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_fixed(K_CSR, CSR_ACCESS, 32'h0badf00d, 32'h00000305, 32'h0badf00d);
        add_fixed(K_FLUSH, ADD, 0, 0, 0);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        // Multiplier, single, back-to-back and flushed
        add_random(K_MUL, MUL);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_random(K_MUL, MULH);
        add_random(K_MUL, MULHU);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
        add_random(K_MUL, MUL);
        add_fixed(K_FLUSH, ADD, 0, 0, 0);
        add_fixed(K_IDLE, ADD, 0, 0, 0);
    endtask

    task automatic compare_value(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_strobes();
        alu_valid    = 1'b0;
        branch_valid = 1'b0;
        csr_valid    = 1'b0;
        mult_valid   = 1'b0;
        csr_commit   = 1'b0;
        flush        = 1'b0;
    endtask

    task automatic apply_row(input row_t r, input int idx);
        clear_strobes();
        fu_data.operation                = r.op;
        fu_data.operand_a                = r.a;
        fu_data.operand_b                = r.b;
        fu_data.imm                      = r.imm;
        fu_data.trans_id                 = trans_id_t'(idx);
        pc                               = r.pc;
        is_compressed                    = r.comp;
        branch_predict.taken             = r.pred_taken;
        branch_predict.predicted_address = r.pred_addr;
        case (r.kind)
            K_ALU:    alu_valid = 1'b1;
            K_BR:     branch_valid = 1'b1;
            K_CSR:    csr_valid = 1'b1;
            K_MUL:    mult_valid = 1'b1;
            K_COMMIT: csr_commit = 1'b1;
            K_FLUSH:  flush = 1'b1;
            default:  ;
        endcase
    endtask

    task automatic check_row(input row_t r, input int idx);
        trans_id_t tid;
        tid = trans_id_t'(idx);
        if (r.kind == K_ALU || r.kind == K_BR || r.kind == K_CSR) begin
            compare_value("wb valid", flu_wb.valid, 1'b1);
            compare_value("wb data", flu_wb.data, r.exp_data);
            compare_value("wb trans_id", flu_wb.trans_id, tid);
        end else if (pend_valid && r.kind != K_FLUSH) begin
            compare_value("mult valid", flu_wb.valid, 1'b1);
            compare_value("mult data", flu_wb.data, pend_data);
            compare_value("mult trans_id", flu_wb.trans_id, pend_tid);
        end else begin
            compare_value("wb valid", flu_wb.valid, 1'b0);
        end
        compare_value("resolve_branch", resolve_branch, r.kind == K_BR);
        if (r.kind == K_BR) begin
            compare_value("branch pc", resolved_branch.pc, r.pc);
            compare_value("branch target", resolved_branch.target_address, r.exp_target);
            compare_value("branch taken", resolved_branch.is_taken, r.exp_taken);
            compare_value("branch mispredict", resolved_branch.is_mispredict, r.exp_mis);
            compare_value("exception valid", flu_exception.valid, r.exp_exc);
            if (r.exp_exc) begin
                compare_value("exception cause", flu_exception.cause, CAUSE_INSTR_MISALIGNED);
                compare_value("exception tval", flu_exception.tval, r.exp_target);
            end
        end else begin
            compare_value("exception valid", flu_exception.valid, 1'b0);
        end
        compare_value("flu_ready", flu_ready, !csr_full);
        if (csr_full) begin
            compare_value("csr_addr", csr_addr, stored_addr);
        end
        // Advance the model to the next edge
        if (r.kind == K_COMMIT || r.kind == K_FLUSH) begin
            csr_full = 1'b0;
        end else if (r.kind == K_CSR) begin
            csr_full    = 1'b1;
            stored_addr = r.b[`EX_CSR_ADDR_BITS-1:0];
        end
        pend_valid = (r.kind == K_MUL);
        pend_data  = r.exp_data;
        pend_tid   = tid;
    endtask

    // Idle cycles until the CSR buffer accepts an issue
    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!flu_ready) begin
            if (cycles == READY_LIMIT) begin
                $display("Timeout: flu_ready_o stayed low for %0d cycles", READY_LIMIT);
                $display("TB FAILED");
                $finish;
            end else begin
                @(posedge clk);
                #2;
                clear_strobes();
                pend_valid = 1'b0;
                #34;
                cycles++;
            end
        end
    endtask

    initial begin
        seed           = 32'h6fe4eb1b;
        errors         = 0;
        checks         = 0;
        csr_full       = 1'b0;
        stored_addr    = '0;
        pend_valid     = 1'b0;
        pend_data      = '0;
        pend_tid       = '0;
        rst_n          = 1'b0;
        fu_data        = '0;
        pc             = '0;
        is_compressed  = 1'b0;
        branch_predict = '0;
        clear_strobes();
        build_table();

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        #34;
        compare_value("reset wb valid", flu_wb.valid, 1'b0);
        compare_value("reset resolve_branch", resolve_branch, 1'b0);
        compare_value("reset exception valid", flu_exception.valid, 1'b0);
        compare_value("reset flu_ready", flu_ready, 1'b1);

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].kind == K_CSR) begin
                wait_for_ready();
            end
            @(posedge clk);
            #2;
            apply_row(rows[i], i);
            #34;
            check_row(rows[i], i);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_csr_buffer.sv
rtl/ex_multiplier.sv
rtl/ex_writeback_arbiter.sv
rtl/ex_fixed_latency.sv
test/ex_properties.sv
test/ex_tb.sv
